//--- hw/spi_bus_pkg.sv
// APB request and register-link structs.
// Address windows decoded at the APB port.
package spi_bus_pkg;

  typedef struct packed {
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  // Wishbone-style link, stb and cyc held until ack.
  typedef struct packed {
    logic [4:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        stb;
    logic        cyc;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } wb_rsp_t;

  localparam logic [31:0] REG_BASE   = 32'h1000_1000;
  localparam logic [31:0] REG_LAST   = 32'h1000_1FFF;
  localparam logic [31:0] FLASH_BASE = 32'h3000_0000;
  localparam logic [31:0] FLASH_LAST = 32'h3FFF_FFFF;

endpackage

//--- hw/spi_core_pkg.sv
// SPI master register map, control fields and shift engine structs.
// Register values written by the flash read program.
package spi_core_pkg;

  localparam logic [4:0] ADR_RX0     = 5'h00;
  localparam logic [4:0] ADR_RX1     = 5'h04;
  localparam logic [4:0] ADR_CTRL    = 5'h10;
  localparam logic [4:0] ADR_DIVIDER = 5'h14;
  localparam logic [4:0] ADR_SS      = 5'h18;

  // Go on write, busy on read.
  localparam int CTRL_GO_BIT = 8;
  localparam int CHAR_LEN_W  = 7;
  localparam int SS_NUM      = 8;

  localparam logic [31:0] FLASH_DIVIDER  = 32'd4;
  localparam logic [31:0] FLASH_CTRL     = 32'h0000_0440;
  localparam logic [31:0] FLASH_START    = 32'h0000_0540;
  localparam logic [7:0]  FLASH_READ_CMD = 8'h03;

  typedef struct packed {
    logic                  go;
    logic [CHAR_LEN_W-1:0] char_len;
    logic [15:0]           divider;
    logic [63:0]           tx;
  } shift_cmd_t;

  typedef struct packed {
    logic        busy;
    logic [63:0] rx;
  } shift_sts_t;

endpackage

//--- hw/apb_flash_sequencer.sv
// APB front stage: register pass-through and the flash read program.
module apb_flash_sequencer
  import spi_bus_pkg::*;
  import spi_core_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  apb_req_t    apb_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output wb_req_t     wb_o,
  input  wb_rsp_t     wb_i
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_REG,
    S_SKIP,
    S_DIV,
    S_CTRL,
    S_TX1,
    S_TX0,
    S_SEL,
    S_GO,
    S_POLL,
    S_DESEL,
    S_RX
  } state_t;

  state_t      state_q;
  state_t      next_step;
  wb_req_t     wb_q;
  wb_req_t     step_req;
  logic [31:0] prdata_q;
  logic        pready_q;
  logic        setup;
  logic        in_reg;
  logic        in_flash;

  // Decode only in the setup phase of a transfer.
  assign setup    = apb_i.psel & ~apb_i.penable;
  assign in_reg   = (apb_i.paddr >= REG_BASE) && (apb_i.paddr <= REG_LAST);
  assign in_flash = (apb_i.paddr >= FLASH_BASE) && (apb_i.paddr <= FLASH_LAST);

  // Request and successor of each program step.
  always_comb begin
    step_req     = '0;
    step_req.sel = 4'hF;
    step_req.we  = 1'b1;
    step_req.stb = 1'b1;
    step_req.cyc = 1'b1;
    next_step    = S_IDLE;
    case (state_q)
      S_DIV: begin
        step_req.adr = ADR_DIVIDER;
        step_req.dat = FLASH_DIVIDER;
        next_step    = S_CTRL;
      end
      S_CTRL: begin
        step_req.adr = ADR_CTRL;
        step_req.dat = FLASH_CTRL;
        next_step    = S_TX1;
      end
      S_TX1: begin
        step_req.adr = ADR_RX1;
        step_req.dat = {FLASH_READ_CMD, apb_i.paddr[23:0]};
        next_step    = S_TX0;
      end
      S_TX0: begin
        step_req.adr = ADR_RX0;
        next_step    = S_SEL;
      end
      S_SEL: begin
        step_req.adr = ADR_SS;
        step_req.dat = 32'h1;
        next_step    = S_GO;
      end
      S_GO: begin
        step_req.adr = ADR_CTRL;
        step_req.dat = FLASH_START;
        next_step    = S_POLL;
      end
      S_POLL: begin
        step_req.adr = ADR_CTRL;
        step_req.we  = 1'b0;
        next_step    = S_DESEL;
      end
      S_DESEL: begin
        step_req.adr = ADR_SS;
        next_step    = S_RX;
      end
      S_RX: begin
        step_req.adr = ADR_RX0;
        step_req.we  = 1'b0;
      end
      default: step_req = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q  <= S_IDLE;
      wb_q     <= '0;
      prdata_q <= '0;
      pready_q <= 1'b0;
    end else begin
      pready_q <= 1'b0;
      prdata_q <= '0;
      case (state_q)
        S_IDLE: begin
          if (setup) begin
            if (in_reg) begin
              wb_q.adr <= apb_i.paddr[4:0];
              wb_q.dat <= apb_i.pwdata;
              wb_q.sel <= apb_i.pstrb;
              wb_q.we  <= apb_i.pwrite;
              wb_q.stb <= 1'b1;
              wb_q.cyc <= 1'b1;
              state_q  <= S_REG;
            end else if (in_flash && !apb_i.pwrite) begin
              state_q <= S_DIV;
            end else begin
              state_q <= S_SKIP;
            end
          end
        end
        // Unsupported access, answered with zero.
        S_SKIP: begin
          pready_q <= 1'b1;
          state_q  <= S_IDLE;
        end
        default: begin
          if (wb_q.cyc && wb_i.ack) begin
            wb_q.stb <= 1'b0;
            wb_q.cyc <= 1'b0;
            case (state_q)
              S_REG, S_RX: begin
                prdata_q <= wb_i.dat;
                pready_q <= 1'b1;
                state_q  <= S_IDLE;
              end
              S_POLL: begin
                if (!wb_i.dat[CTRL_GO_BIT]) state_q <= next_step;
              end
              default: state_q <= next_step;
            endcase
          end else if (!wb_q.cyc) begin
            // Idle gap after the last ack.
            wb_q <= step_req;
          end
        end
      endcase
    end
  end

  assign wb_o     = wb_q;
  assign prdata_o = prdata_q;
  assign pready_o = pready_q;

endmodule

//--- hw/spi_wb_regs.sv
// SPI register stage: divider, control, data and select registers.
module spi_wb_regs
  import spi_bus_pkg::*;
  import spi_core_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  wb_req_t           wb_i,
  output wb_rsp_t           wb_o,
  output shift_cmd_t        cmd_o,
  input  shift_sts_t        sts_i,
  output logic [SS_NUM-1:0] ss_o
);

  logic [15:0]       divider_q;
  logic [15:0]       ctrl_q;
  logic [31:0]       tx0_q;
  logic [31:0]       tx1_q;
  logic [SS_NUM-1:0] ss_q;
  logic [31:0]       dat_q;
  logic              ack_q;
  logic              go_q;
  logic              access;
  logic              wr_en;
  logic [31:0]       div_wr;
  logic [31:0]       ctrl_wr;
  logic [31:0]       ctrl_rd;
  logic [31:0]       rd_data;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  sel);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) word[8*b +: 8] = new_word[8*b +: 8];
    end
    return word;
  endfunction

  // First cycle of a request only.
  assign access = wb_i.stb & wb_i.cyc & ~ack_q;
  assign wr_en  = access & wb_i.we & ~sts_i.busy & ~go_q;

  always_comb begin
    div_wr  = merge_bytes({16'b0, divider_q}, wb_i.dat, wb_i.sel);
    ctrl_wr = merge_bytes({16'b0, ctrl_q}, wb_i.dat, wb_i.sel);
    ctrl_wr[CTRL_GO_BIT] = 1'b0;
    ctrl_rd = {16'b0, ctrl_q};
    ctrl_rd[CTRL_GO_BIT] = sts_i.busy | go_q;
    case (wb_i.adr)
      ADR_RX0:     rd_data = sts_i.rx[31:0];
      ADR_RX1:     rd_data = sts_i.rx[63:32];
      ADR_CTRL:    rd_data = ctrl_rd;
      ADR_DIVIDER: rd_data = {16'b0, divider_q};
      ADR_SS:      rd_data = {{(32-SS_NUM){1'b0}}, ss_q};
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      divider_q <= '0;
      ctrl_q    <= '0;
      ss_q      <= '0;
      go_q      <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= access;
      go_q  <= 1'b0;
      if (wr_en) begin
        case (wb_i.adr)
          ADR_DIVIDER: divider_q <= div_wr[15:0];
          ADR_CTRL: begin
            ctrl_q <= ctrl_wr[15:0];
            go_q   <= wb_i.sel[1] & wb_i.dat[CTRL_GO_BIT];
          end
          ADR_SS: begin
            if (wb_i.sel[0]) ss_q <= wb_i.dat[SS_NUM-1:0];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access) dat_q <= rd_data;
    if (wr_en && wb_i.adr == ADR_RX0) tx0_q <= merge_bytes(tx0_q, wb_i.dat, wb_i.sel);
    if (wr_en && wb_i.adr == ADR_RX1) tx1_q <= merge_bytes(tx1_q, wb_i.dat, wb_i.sel);
  end

  assign wb_o.dat       = dat_q;
  assign wb_o.ack       = ack_q;
  assign cmd_o.go       = go_q;
  assign cmd_o.char_len = ctrl_q[CHAR_LEN_W-1:0];
  assign cmd_o.divider  = divider_q;
  assign cmd_o.tx       = {tx1_q, tx0_q};
  // Selects are active low.
  assign ss_o = ~ss_q;

endmodule

//--- hw/spi_shift_engine.sv
// SPI clock generator and 64-bit shift register, MSB first.
module spi_shift_engine
  import spi_core_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  shift_cmd_t cmd_i,
  output shift_sts_t sts_o,
  output logic       sclk_o,
  output logic       mosi_o,
  input  logic       miso_i
);

  logic [CHAR_LEN_W-1:0] len;
  logic [CHAR_LEN_W-1:0] shift_amt;
  logic [CHAR_LEN_W:0]   last_edge;
  logic [CHAR_LEN_W:0]   edge_q;
  logic [15:0]           cnt_q;
  logic [63:0]           tx_q;
  logic [63:0]           rx_q;
  logic                  sck_q;
  logic                  busy_q;
  logic                  start;
  logic                  tick;

  // Zero length means a full 64-bit word.
  assign len = (cmd_i.char_len[CHAR_LEN_W-2:0] == '0) ? CHAR_LEN_W'(64)
             : {1'b0, cmd_i.char_len[CHAR_LEN_W-2:0]};
  assign shift_amt = CHAR_LEN_W'(64) - len;
  assign last_edge = {len, 1'b0} - 1'b1;
  assign start     = cmd_i.go & ~busy_q;
  assign tick      = busy_q & (cnt_q == cmd_i.divider);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
      sck_q  <= 1'b0;
      cnt_q  <= '0;
      edge_q <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
      edge_q <= '0;
    end else if (tick) begin
      cnt_q  <= '0;
      sck_q  <= ~sck_q;
      edge_q <= edge_q + 1'b1;
      if (edge_q == last_edge) busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Shift out on falling SCK, sample on rising SCK.
  always_ff @(posedge clock) begin
    if (start) tx_q <= cmd_i.tx << shift_amt;
    else if (tick && sck_q) tx_q <= {tx_q[62:0], 1'b0};
    if (tick && !sck_q) rx_q <= {rx_q[62:0], miso_i};
  end

  assign sclk_o     = sck_q;
  assign mosi_o     = busy_q & tx_q[63];
  assign sts_o.busy = busy_q;
  assign sts_o.rx   = rx_q;

endmodule

//--- hw/spi_flash_bridge.sv
// APB to SPI bridge top: sequencer, register stage and shift engine.
module spi_flash_bridge
  import spi_bus_pkg::*;
  import spi_core_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  apb_req_t          apb_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              spi_sck_o,
  output logic [SS_NUM-1:0] spi_ss_o,
  output logic              spi_mosi_o,
  input  logic              spi_miso_i
);

  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  shift_cmd_t shift_cmd;
  shift_sts_t shift_sts;

  apb_flash_sequencer i_apb_flash_sequencer (
    .clock    (clock),
    .reset    (reset),
    .apb_i    (apb_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .wb_o     (wb_req),
    .wb_i     (wb_rsp)
  );

  spi_wb_regs i_spi_wb_regs (
    .clock (clock),
    .reset (reset),
    .wb_i  (wb_req),
    .wb_o  (wb_rsp),
    .cmd_o (shift_cmd),
    .sts_i (shift_sts),
    .ss_o  (spi_ss_o)
  );

  spi_shift_engine i_spi_shift_engine (
    .clock  (clock),
    .reset  (reset),
    .cmd_i  (shift_cmd),
    .sts_o  (shift_sts),
    .sclk_o (spi_sck_o),
    .mosi_o (spi_mosi_o),
    .miso_i (spi_miso_i)
  );

endmodule

//--- sim/spi_flash_model.sv
// Behavioral SPI flash: read command, 24-bit address, pattern data MSB first.
module spi_flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o,
  output int   error_count_o
);

  logic [31:0] header_q;
  logic [23:0] addr_q;
  int          bit_cnt;

  // Byte at an address is its low byte XOR 0xA5.
  function automatic logic data_bit(input int index);
    logic [23:0] byte_addr;
    logic [7:0]  value;
    byte_addr = addr_q + 24'(index / 8);
    value     = byte_addr[7:0] ^ 8'hA5;
    return value[7 - index % 8];
  endfunction

  initial begin
    miso_o        = 1'b0;
    error_count_o = 0;
    bit_cnt       = 0;
    header_q      = '0;
    addr_q        = '0;
  end

  // Command and address come in on rising SCK.
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt = 0;
    end else begin
      if (bit_cnt < 32) header_q = {header_q[30:0], mosi_i};
      if (bit_cnt == 31) begin
        addr_q = header_q[23:0];
        assert (header_q[31:24] == 8'h03) else begin
          error_count_o++;
          $display("Flash model received command 0x%02h at time %0t, expected read command 0x03",
                   header_q[31:24], $time);
        end
      end
      bit_cnt++;
    end
  end

  // Read data goes out on falling SCK.
  always @(negedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      miso_o <= 1'b0;
    end else if (bit_cnt >= 32 && bit_cnt < 64) begin
      miso_o <= data_bit(bit_cnt - 32);
    end
  end

endmodule

//--- sim/tb_spi_flash_bridge.sv
// Testbench for the APB SPI flash bridge with a behavioral flash on select 0.
// Reference flash word, register shadows, response compare and run limit.
module tb_spi_flash_bridge
  import spi_bus_pkg::*;
  import spi_core_pkg::*;
();

  localparam int FLASH_READS = 20;
  localparam int CYCLE_LIMIT = FLASH_READS * 800 + 2000;

  logic              clock;
  logic              reset;
  apb_req_t          apb;
  logic [31:0]       prdata;
  logic              pready;
  logic              spi_sck;
  logic [SS_NUM-1:0] spi_ss;
  logic              spi_mosi;
  logic              spi_miso;
  int                flash_errors;
  int                mismatches = 0;
  int                failures = 0;
  int                checks = 0;
  int                cycles = 0;
  // Bit 32 set when the read data is compared.
  logic [32:0]       expect_q[$];
  logic [15:0]       div_model;
  logic [7:0]        ss_model;

  spi_flash_bridge i_spi_flash_bridge (
    .clock      (clock),
    .reset      (reset),
    .apb_i      (apb),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso)
  );

  spi_flash_model i_spi_flash_model (
    .sck_i         (spi_sck),
    .ss_n_i        (spi_ss[0]),
    .mosi_i        (spi_mosi),
    .miso_o        (spi_miso),
    .error_count_o (flash_errors)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Expected flash word with the byte at addr in the top bits.
  function automatic logic [31:0] flash_word(input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  low;
    word = '0;
    for (int i = 0; i < 4; i++) begin
      low = addr[7:0] + 8'(i);
      word[31 - 8*i -: 8] = low ^ 8'hA5;
    end
    return word;
  endfunction

  function automatic logic [31:0] apply_strobes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  task automatic report_counts();
    $display("Checked %0d responses: %0d mismatches, %0d other failures, %0d flash errors",
             checks, mismatches, failures, flash_errors);
  endtask

  // One APB transfer held until pready.
  task automatic apb_transfer(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              input logic check, input logic [31:0] expected);
    expect_q.push_back({check, expected});
    apb.paddr   = addr;
    apb.pwrite  = write;
    apb.pwdata  = wdata;
    apb.pstrb   = strb;
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    @(posedge clock);
    #1;
    apb.penable = 1'b1;
    @(negedge clock);
    while (!pready) @(negedge clock);
    @(posedge clock);
    #1;
    apb.psel    = 1'b0;
    apb.penable = 1'b0;
  endtask

  task automatic reg_write(input logic [4:0] offset, input logic [31:0] data,
                           input logic [3:0] strb);
    apb_transfer(REG_BASE | 32'(offset), 1'b1, data, strb, 1'b0, '0);
    if (offset == ADR_DIVIDER) div_model = 16'(apply_strobes({16'b0, div_model}, data, strb));
    if (offset == ADR_SS) ss_model = 8'(apply_strobes({24'b0, ss_model}, data, strb));
  endtask

  task automatic reg_read(input logic [4:0] offset, input logic [31:0] expected);
    apb_transfer(REG_BASE | 32'(offset), 1'b0, '0, 4'h0, 1'b1, expected);
  endtask

  task automatic check_regs();
    reg_read(ADR_DIVIDER, {16'b0, div_model});
    reg_read(ADR_SS, {24'b0, ss_model});
    assert (spi_ss === ~ss_model) else begin
      mismatches++;
      $display("Mismatch at time %0t: ss lines 0x%02h, expected 0x%02h", $time, spi_ss,
               ~ss_model);
    end
  endtask

  // The flash program leaves divider, control and select rewritten.
  task automatic flash_read(input logic [31:0] addr);
    apb_transfer(addr, 1'b0, '0, 4'h0, 1'b1, flash_word(addr));
    assert (spi_ss === '1) else begin
      mismatches++;
      $display("Mismatch at time %0t: ss lines 0x%02h after flash read", $time, spi_ss);
    end
    reg_read(ADR_CTRL, FLASH_CTRL);
    div_model = 16'(FLASH_DIVIDER);
    ss_model  = '0;
  endtask

  always @(negedge clock) begin : compare_resp
    logic [32:0] entry;
    if (pready) begin
      assert (expect_q.size() > 0) else begin
        failures++;
        $display("pready pulsed at time %0t with no transfer in progress", $time);
      end
      if (expect_q.size() > 0) begin
        entry = expect_q.pop_front();
        checks++;
        if (entry[32]) begin
          assert (prdata === entry[31:0]) else begin
            mismatches++;
            $display("Mismatch at time %0t: prdata 0x%08h, expected 0x%08h", $time, prdata,
                     entry[31:0]);
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] addr;
    void'($urandom(9400));
    reset     = 1'b1;
    apb       = '0;
    div_model = '0;
    ss_model  = '0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (8) begin
      @(posedge clock);
      #1;
      assert (spi_ss === '1 && spi_sck === 1'b0 && pready === 1'b0 && spi_mosi === 1'b0)
      else begin
        mismatches++;
        $display("Mismatch at time %0t: idle ss 0x%02h sck %b pready %b mosi %b", $time,
                 spi_ss, spi_sck, pready, spi_mosi);
      end
    end
    check_regs();
    reg_write(ADR_DIVIDER, 32'h0000_1234, 4'hF);
    check_regs();
    reg_write(ADR_DIVIDER, 32'hDEAD_BEEF, 4'h1);
    check_regs();
    reg_write(ADR_DIVIDER, 32'hFFFF_56FF, 4'h2);
    reg_write(ADR_SS, 32'h0000_00A4, 4'hF);
    check_regs();
    reg_write(ADR_SS, 32'h0000_0033, 4'hE);
    check_regs();
    // Accesses outside both windows and a flash write, all at the divider offset.
    apb_transfer(32'h2000_0014, 1'b0, '0, 4'h0, 1'b1, 32'h0);
    apb_transfer(32'h0000_0054, 1'b1, 32'hFFFF_FFFF, 4'hF, 1'b1, 32'h0);
    apb_transfer(32'h3000_1234, 1'b1, 32'h1234_5678, 4'hF, 1'b1, 32'h0);
    apb_transfer(32'h1000_2014, 1'b0, '0, 4'h0, 1'b1, 32'h0);
    apb_transfer(32'h4000_0014, 1'b0, '0, 4'h0, 1'b1, 32'h0);
    check_regs();
    repeat (16) begin
      addr = FLASH_BASE | ($urandom() & 32'h0FFF_FFFF);
      flash_read(addr);
    end
    // Register traffic around the last reads.
    for (int i = 0; i < 4; i++) begin
      reg_write(ADR_DIVIDER, $urandom(), 4'hF);
      reg_write(ADR_SS, $urandom() & 32'hFE, 4'h1);
      check_regs();
      if (i == 0) addr = FLASH_BASE;
      else if (i == 3) addr = FLASH_LAST;
      else addr = FLASH_BASE | ($urandom() & 32'h0FFF_FFFF);
      flash_read(addr);
      check_regs();
    end
    report_counts();
    if (mismatches + failures + flash_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing", cycles);
    report_counts();
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- spi_flash_bridge.f
hw/spi_bus_pkg.sv
hw/spi_core_pkg.sv
hw/apb_flash_sequencer.sv
hw/spi_wb_regs.sv
hw/spi_shift_engine.sv
hw/spi_flash_bridge.sv
sim/spi_flash_model.sv
sim/tb_spi_flash_bridge.sv

//--- Bender.yml
package:
  name: spi_flash_bridge

sources:
  - hw/spi_bus_pkg.sv
  - hw/spi_core_pkg.sv
  - hw/apb_flash_sequencer.sv
  - hw/spi_wb_regs.sv
  - hw/spi_shift_engine.sv
  - hw/spi_flash_bridge.sv
  - target: simulation
    files:
      - sim/spi_flash_model.sv
      - sim/tb_spi_flash_bridge.sv
